// File: tb.f
logic/dispatch_pkg.sv
logic/cpu_scheduler.sv
logic/mem_bridge.sv
logic/cpu_dispatcher.sv
tb/tb_cpu_dispatcher.sv

// File: Bender.yml
package:
  name: cpu_dispatcher

sources:
  # package first, then leaf modules, then top
  - logic/dispatch_pkg.sv
  - logic/cpu_scheduler.sv
  - logic/mem_bridge.sv
  - logic/cpu_dispatcher.sv

  - target: test
    files:
      - tb/tb_cpu_dispatcher.sv

// File: tb/tb_cpu_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dispatcher;

  import dispatch_pkg::*;

  // generous bound over all phases below
  localparam int MAX_CYCLES = 2000;

  logic clk = 1'b0;
  logic ext_rst_e;
  cpu_req_t cpu_req;
  cpu_msg_e cpu_msg;
  logic ext_cpu_e;
  logic ext_bus_q;
  // memory model drives these
  logic ext_read_dn = 1'b0;
  logic ext_write_dn = 1'b0;
  logic [DATA_W-1:0] ext_mem_rdata = '0;

  cpu_index_t cpu_index;
  logic ext_cpu_q;
  logic read_dn;
  logic write_dn;
  logic [DATA_W-1:0] data_out;
  logic bus_busy;
  logic ext_bus_allow;
  mem_req_t ext_mem_req;

  // memory model state
  int unsigned wait_cnt = 0;
  logic pend_read = 1'b0;
  logic [ADDR_W-1:0] seen_addr = '0;
  logic [DATA_W-1:0] seen_data = '0;
  // answer for the next request, chosen by the stimulus
  int unsigned next_delay = 1;
  logic [DATA_W-1:0] next_rdata = '0;

  // expected accounting and slot sequence
  int exp_act = 0;
  int exp_inact = CPU_QUANTITY;
  int exp_rr = 0;
  logic prev_inactive = 1'b0;
  int unsigned cycles = 0;

  cpu_dispatcher UUT (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_req       (cpu_req),
    .cpu_msg       (cpu_msg),
    .ext_cpu_e     (ext_cpu_e),
    .cpu_index     (cpu_index),
    .ext_cpu_q     (ext_cpu_q),
    .read_dn       (read_dn),
    .write_dn      (write_dn),
    .data_out      (data_out),
    .bus_busy      (bus_busy),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .ext_mem_req   (ext_mem_req)
  );

  always #50 clk = ~clk;

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got,
                          input logic [63:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
      abort_run();
    end
  end

  // memory with a random answer delay
  always @(negedge clk) begin
    ext_read_dn  <= 1'b0;
    ext_write_dn <= 1'b0;
    if (ext_mem_req.read_q || ext_mem_req.write_q) begin
      pend_read <= ext_mem_req.read_q;
      wait_cnt  <= next_delay;
    end else if (wait_cnt != 0) begin
      wait_cnt <= wait_cnt - 1;
      if (wait_cnt == 1) begin
        // port contents still held when the answer goes out
        seen_addr     <= ext_mem_req.addr;
        seen_data     <= ext_mem_req.data;
        ext_read_dn   <= pend_read;
        ext_write_dn  <= !pend_read;
        ext_mem_rdata <= next_rdata;
      end
    end
  end

  // offer strobe is one cycle wide
  assert property (@(posedge clk) disable iff (ext_rst_e) ext_cpu_q |=> !ext_cpu_q)
    else begin
      $display("** Error: ext_cpu_q = 0x%0h, expected 0x0 after a pulse", $sampled(ext_cpu_q));
      abort_run();
    end

  // read done reaches the cpu two cycles after the memory done
  assert property (@(posedge clk) disable iff (ext_rst_e)
    ext_read_dn |-> ##2 (read_dn && bus_busy))
    else begin
      $display("** Error: read_dn = 0x%0h, bus_busy = 0x%0h, expected 0x1 after ext_read_dn",
               $sampled(read_dn), $sampled(bus_busy));
      abort_run();
    end

  assert property (@(posedge clk) disable iff (ext_rst_e) ext_write_dn |-> ##2 write_dn)
    else begin
      $display("** Error: write_dn = 0x%0h, expected 0x1 after ext_write_dn", $sampled(write_dn));
      abort_run();
    end

  assert property (@(posedge clk) disable iff (ext_rst_e) bus_busy |=> !bus_busy)
    else begin
      $display("** Error: bus_busy = 0x%0h, expected 0x0 one cycle later", $sampled(bus_busy));
      abort_run();
    end

  // no offers while the bus is handed out
  assert property (@(posedge clk) disable iff (ext_rst_e) ext_bus_allow |-> !ext_cpu_q)
    else begin
      $display("** Error: ext_cpu_q = 0x%0h while ext_bus_allow is set", $sampled(ext_cpu_q));
      abort_run();
    end

  // slot rule from the expected counts, then wait for the pulse
  task automatic expect_offer();
    logic exp_active;
    int exp_num;
    if (exp_inact > 0 && !prev_inactive) begin
      exp_active    = 1'b0;
      exp_num       = 0;
      prev_inactive = 1'b1;
    end else begin
      exp_active = 1'b1;
      if (exp_act == 0 || exp_rr >= exp_act - 1)
        exp_rr = 0;
      else
        exp_rr = exp_rr + 1;
      exp_num       = exp_rr;
      prev_inactive = 1'b0;
    end
    while (!ext_cpu_q)
      @(negedge clk);
    check_eq("cpu_index.active", cpu_index.active, exp_active);
    check_eq("cpu_index.num", cpu_index.num, exp_num);
  endtask

  task automatic send_msg(input cpu_msg_e msg);
    ext_cpu_e = 1'b1;
    cpu_msg   = msg;
    @(negedge clk);
    ext_cpu_e = 1'b0;
    cpu_msg   = CPU_R_NONE;
    // counts saturate at the pool size
    if (msg == CPU_R_START && exp_inact > 0) begin
      exp_inact = exp_inact - 1;
      exp_act   = exp_act + 1;
    end else if (msg == CPU_R_END && exp_act > 0) begin
      exp_act   = exp_act - 1;
      exp_inact = exp_inact + 1;
    end
  endtask

  task automatic read_access();
    logic [ADDR_W-1:0] addr;
    addr          = ADDR_W'($urandom);
    next_delay    = 1 + ($urandom % 8);
    next_rdata    = DATA_W'($urandom);
    cpu_req       = '0;
    cpu_req.read_q = 1'b1;
    cpu_req.addr  = addr;
    @(negedge clk);
    cpu_req = '0;
    while (!ext_mem_req.read_q)
      @(negedge clk);
    check_eq("ext_mem_req.addr", ext_mem_req.addr, addr);
    while (!read_dn)
      @(negedge clk);
    // address held up to the answer, port idle afterwards
    check_eq("seen_addr", seen_addr, addr);
    check_eq("ext_mem_req", ext_mem_req, '0);
    check_eq("data_out", data_out, next_rdata);
    check_eq("bus_busy", bus_busy, 1'b1);
    @(negedge clk);
    check_eq("bus_busy", bus_busy, 1'b0);
  endtask

  task automatic write_access();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    addr           = ADDR_W'($urandom);
    data           = DATA_W'($urandom);
    next_delay     = 1 + ($urandom % 8);
    next_rdata     = DATA_W'($urandom);
    cpu_req        = '0;
    cpu_req.write_q = 1'b1;
    cpu_req.addr   = addr;
    cpu_req.data   = data;
    @(negedge clk);
    cpu_req = '0;
    while (!ext_mem_req.write_q)
      @(negedge clk);
    check_eq("ext_mem_req.addr", ext_mem_req.addr, addr);
    check_eq("ext_mem_req.data", ext_mem_req.data, data);
    while (!write_dn)
      @(negedge clk);
    // what the memory model saw when it answered
    check_eq("seen_addr", seen_addr, addr);
    check_eq("seen_data", seen_data, data);
    check_eq("ext_mem_req", ext_mem_req, '0);
    // port data echoed on a write
    check_eq("data_out", data_out, next_rdata);
    check_eq("bus_busy", bus_busy, 1'b1);
  endtask

  // offer, a silent pause, then one read or write
  task automatic random_access();
    expect_offer();
    repeat ($urandom % 3)
      @(negedge clk);
    if ($urandom % 2)
      read_access();
    else
      write_access();
  endtask

  task automatic hold_ext_bus(input int held);
    ext_bus_q = 1'b1;
    for (int i = 1; i <= held; i++) begin
      @(negedge clk);
      check_eq("ext_cpu_q", ext_cpu_q, 1'b0);
      // grant lags the request by a cycle
      if (i >= 2)
        check_eq("ext_bus_allow", ext_bus_allow, 1'b1);
    end
    ext_bus_q = 1'b0;
    @(negedge clk);
    check_eq("ext_bus_allow", ext_bus_allow, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h36b5_a1b3));
    ext_rst_e = 1'b1;
    cpu_req   = '0;
    cpu_msg   = CPU_R_NONE;
    ext_cpu_e = 1'b0;
    ext_bus_q = 1'b0;
    repeat (5)
      @(negedge clk);
    check_eq("ext_cpu_q", ext_cpu_q, 1'b0);
    check_eq("read_dn", read_dn, 1'b0);
    check_eq("write_dn", write_dn, 1'b0);
    check_eq("bus_busy", bus_busy, 1'b0);
    check_eq("ext_bus_allow", ext_bus_allow, 1'b0);
    check_eq("ext_mem_req", ext_mem_req, '0);
    ext_rst_e = 1'b0;
    // one start more than the pool holds
    repeat (CPU_QUANTITY + 1) begin
      expect_offer();
      send_msg(CPU_R_START);
    end
    repeat (12)
      random_access();
    // one cpu leaves, inactive slot comes back
    expect_offer();
    send_msg(CPU_R_END);
    repeat (8)
      random_access();
    expect_offer();
    send_msg(CPU_R_NONE);
    hold_ext_bus(2 + ($urandom % 4));
    repeat (6)
      random_access();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/cpu_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatcher (
  input  wire                               clk,
  input  wire                               ext_rst_e,
  // polled cpu side
  input  wire dispatch_pkg::cpu_req_t       cpu_req,
  input  wire dispatch_pkg::cpu_msg_e       cpu_msg,
  input  wire                               ext_cpu_e,
  output dispatch_pkg::cpu_index_t          cpu_index,
  output logic                              ext_cpu_q,
  output logic                              read_dn,
  output logic                              write_dn,
  output logic [dispatch_pkg::DATA_W-1:0]   data_out,
  output logic                              bus_busy,
  // external bus request
  input  wire                               ext_bus_q,
  output logic                              ext_bus_allow,
  // external memory port
  input  wire                               ext_read_dn,
  input  wire                               ext_write_dn,
  input  wire [dispatch_pkg::DATA_W-1:0]    ext_mem_rdata,
  output dispatch_pkg::mem_req_t            ext_mem_req
);

  import dispatch_pkg::*;

  // scheduler to bridge
  logic     mem_start;
  mem_op_e  mem_op;
  cpu_req_t mem_addr_data;

  // bridge back to scheduler
  logic              mem_done;
  logic [DATA_W-1:0] mem_rdata;

  cpu_scheduler u_scheduler (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_req       (cpu_req),
    .cpu_msg       (cpu_msg),
    .ext_cpu_e     (ext_cpu_e),
    .ext_bus_q     (ext_bus_q),
    .mem_done      (mem_done),
    .mem_rdata     (mem_rdata),
    .cpu_index     (cpu_index),
    .ext_cpu_q     (ext_cpu_q),
    .read_dn       (read_dn),
    .write_dn      (write_dn),
    .bus_busy      (bus_busy),
    .data_out      (data_out),
    .ext_bus_allow (ext_bus_allow),
    .mem_start     (mem_start),
    .mem_op        (mem_op),
    .mem_addr_data (mem_addr_data)
  );

  // single pending request toward memory
  mem_bridge u_bridge (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .mem_start     (mem_start),
    .mem_op        (mem_op),
    .mem_addr_data (mem_addr_data),
    .ext_read_dn   (ext_read_dn),
    .ext_write_dn  (ext_write_dn),
    .ext_mem_rdata (ext_mem_rdata),
    .ext_mem_req   (ext_mem_req),
    .mem_done      (mem_done),
    .mem_rdata     (mem_rdata)
  );

endmodule

`default_nettype wire

// File: logic/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
  input  wire                               clk,
  input  wire                               ext_rst_e,
  input  wire                               mem_start,
  input  wire dispatch_pkg::mem_op_e        mem_op,
  input  wire dispatch_pkg::cpu_req_t       mem_addr_data,
  input  wire                               ext_read_dn,
  input  wire                               ext_write_dn,
  input  wire [dispatch_pkg::DATA_W-1:0]    ext_mem_rdata,
  output dispatch_pkg::mem_req_t            ext_mem_req,
  output logic                              mem_done,
  output logic [dispatch_pkg::DATA_W-1:0]   mem_rdata
);

  import dispatch_pkg::*;

  // operation still waiting for its done
  mem_op_e pend_op;
  logic    done_hit;

  // only the done matching the pending op counts
  assign done_hit = ((pend_op == MEM_READ) && ext_read_dn) ||
                    ((pend_op == MEM_WRITE) && ext_write_dn);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      pend_op     <= MEM_NONE;
      ext_mem_req <= '0;
      mem_done    <= 1'b0;
    end else begin
      mem_done            <= 1'b0;
      // request strobes last one cycle
      ext_mem_req.read_q  <= 1'b0;
      ext_mem_req.write_q <= 1'b0;

      if (mem_start) begin
        pend_op             <= mem_op;
        ext_mem_req.read_q  <= (mem_op == MEM_READ);
        ext_mem_req.write_q <= (mem_op == MEM_WRITE);
        // address and data hold until done
        ext_mem_req.addr    <= mem_addr_data.addr;
        ext_mem_req.data    <= mem_addr_data.data;
      end else if (done_hit) begin
        // write done also returns the port data
        mem_rdata   <= ext_mem_rdata;
        mem_done    <= 1'b1;
        pend_op     <= MEM_NONE;
        ext_mem_req <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cpu_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_scheduler (
  input  wire                               clk,
  input  wire                               ext_rst_e,
  input  wire dispatch_pkg::cpu_req_t       cpu_req,
  input  wire dispatch_pkg::cpu_msg_e       cpu_msg,
  input  wire                               ext_cpu_e,
  input  wire                               ext_bus_q,
  input  wire                               mem_done,
  input  wire [dispatch_pkg::DATA_W-1:0]    mem_rdata,
  output dispatch_pkg::cpu_index_t          cpu_index,
  output logic                              ext_cpu_q,
  output logic                              read_dn,
  output logic                              write_dn,
  output logic                              bus_busy,
  output logic [dispatch_pkg::DATA_W-1:0]   data_out,
  output logic                              ext_bus_allow,
  output logic                              mem_start,
  output dispatch_pkg::mem_op_e             mem_op,
  output dispatch_pkg::cpu_req_t            mem_addr_data
);

  import dispatch_pkg::*;

  ctl_state_e state;

  // cpu accounting
  logic [CPU_NUM_W-1:0] a_cnt;
  logic [CPU_NUM_W-1:0] na_cnt;

  // round robin position among active cpus
  logic [CPU_NUM_W-1:0] rr_num;
  logic [CPU_NUM_W-1:0] rr_next;
  logic                 rr_wrap;

  // previous offer went to the inactive slot
  logic inactive_offered;
  logic offer_inactive;

  // wrap after the last active cpu, or stay at 0 with none active
  assign rr_wrap = (a_cnt == '0) || (rr_num >= a_cnt - 1'b1);
  assign rr_next = rr_wrap ? '0 : rr_num + 1'b1;

  // inactive slot alternates with active turns while any cpu is idle
  assign offer_inactive = (na_cnt != '0) && !inactive_offered;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state            <= CTL_CPU_LOOP;
      a_cnt            <= '0;
      na_cnt           <= CPU_NUM_W'(CPU_QUANTITY);
      rr_num           <= '0;
      inactive_offered <= 1'b0;
      ext_cpu_q        <= 1'b0;
      read_dn          <= 1'b0;
      write_dn         <= 1'b0;
      bus_busy         <= 1'b0;
      ext_bus_allow    <= 1'b0;
      mem_start        <= 1'b0;
      mem_op           <= MEM_NONE;
    end else begin
      // one cycle strobes
      ext_cpu_q <= 1'b0;
      read_dn   <= 1'b0;
      write_dn  <= 1'b0;
      mem_start <= 1'b0;

      case (state)
        CTL_CPU_LOOP: begin
          if (bus_busy) begin
            // one idle cycle after a completion
            bus_busy <= 1'b0;
          end else if (ext_bus_q) begin
            state <= CTL_CPU_EXT_BUS;
          end else begin
            if (offer_inactive) begin
              cpu_index.active <= 1'b0;
              cpu_index.num    <= '0;
              inactive_offered <= 1'b1;
            end else begin
              cpu_index.active <= 1'b1;
              cpu_index.num    <= rr_next;
              rr_num           <= rr_next;
              inactive_offered <= 1'b0;
            end
            ext_cpu_q <= 1'b1;
            state     <= CTL_CPU_CMD;
          end
        end

        CTL_CPU_CMD: begin
          // wait for the offered cpu to answer
          if (cpu_req.read_q) begin
            mem_start     <= 1'b1;
            mem_op        <= MEM_READ;
            mem_addr_data <= cpu_req;
            state         <= CTL_MEM_WORK;
          end else if (cpu_req.write_q) begin
            mem_start     <= 1'b1;
            mem_op        <= MEM_WRITE;
            mem_addr_data <= cpu_req;
            state         <= CTL_MEM_WORK;
          end else if (ext_cpu_e) begin
            case (cpu_msg)
              CPU_R_START: begin
                // no more starts than idle cpus
                if (na_cnt != '0) begin
                  na_cnt <= na_cnt - 1'b1;
                  a_cnt  <= a_cnt + 1'b1;
                end
              end
              CPU_R_END: begin
                if (a_cnt != '0) begin
                  a_cnt  <= a_cnt - 1'b1;
                  na_cnt <= na_cnt + 1'b1;
                end
              end
              default: begin
              end
            endcase
            state <= CTL_CPU_LOOP;
          end
        end

        CTL_MEM_WORK: begin
          // bridge owns the transfer until done
          if (mem_done) begin
            read_dn  <= (mem_op == MEM_READ);
            write_dn <= (mem_op == MEM_WRITE);
            bus_busy <= 1'b1;
            data_out <= mem_rdata;
            mem_op   <= MEM_NONE;
            state    <= CTL_CPU_LOOP;
          end
        end

        CTL_CPU_EXT_BUS: begin
          // grant follows the request one cycle late
          ext_bus_allow <= ext_bus_q;
          if (!ext_bus_q) begin
            state <= CTL_CPU_LOOP;
          end
        end

        default: begin
          state <= CTL_CPU_LOOP;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

  // bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 16;

  // cpu pool size
  localparam int CPU_QUANTITY = 4;
  // cpu number and counts, wide enough to hold CPU_QUANTITY itself
  localparam int CPU_NUM_W = 3;

  // dispatcher controller states
  typedef enum logic [1:0] {
    CTL_CPU_LOOP,
    CTL_CPU_CMD,
    CTL_MEM_WORK,
    CTL_CPU_EXT_BUS
  } ctl_state_e;

  // messages a polled cpu may report
  typedef enum logic [1:0] {
    CPU_R_NONE  = 2'd0,
    CPU_R_START = 2'd1,
    CPU_R_END   = 2'd2
  } cpu_msg_e;

  // pending memory operation
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_READ  = 2'd1,
    MEM_WRITE = 2'd2
  } mem_op_e;

  // request from the polled cpu
  typedef struct packed {
    logic              read_q;
    logic              write_q;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cpu_req_t;

  // request on the external memory port
  typedef struct packed {
    logic              read_q;
    logic              write_q;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  // slot offered with ext_cpu_q
  typedef struct packed {
    logic                 active;
    logic [CPU_NUM_W-1:0] num;
  } cpu_index_t;

endpackage

`default_nettype wire
